// File: design/sui_params.svh
// Sizing defines for the SIMD upstream interface
//   Lane array and upstream bus widths
//   Beat and tag sizing
//   Beat FIFO depth and almost-full threshold

`ifndef SUI_PARAMS_SVH
`define SUI_PARAMS_SVH

// ----------------------------------------------------------
// SIMD register array
`define SUI_NUM_LANES       8
`define SUI_LANE_WIDTH      32

// ----------------------------------------------------------
// Upstream stack bus
`define SUI_BUS_WIDTH       64
`define SUI_LANES_PER_BEAT  2   // Lanes packed into one beat
`define SUI_NUM_BEATS       4   // Beats per message
`define SUI_TAG_WIDTH       8

// ----------------------------------------------------------
// Beat FIFO
`define SUI_FIFO_DEPTH      8
`define SUI_FIFO_THRESHOLD  6   // almost_full at this occupancy

`endif

// File: design/sui_pkg.sv
// Shared types for the SIMD upstream interface
//   Vector typedefs for lanes, bus data, tag and beat index
//   Message marker, packet type and controller state enums

`include "sui_params.svh"

package sui_pkg;

  // ----------------------------------------------------------
  // Vectors
  typedef logic [`SUI_LANE_WIDTH-1:0]                lane_t;
  typedef logic [`SUI_NUM_LANES*`SUI_LANE_WIDTH-1:0] lane_array_t;  // Lane 0 in the low bits
  typedef logic [`SUI_BUS_WIDTH-1:0]                 bus_data_t;
  typedef logic [`SUI_TAG_WIDTH-1:0]                 tag_t;         // Carried as oob data
  typedef logic [$clog2(`SUI_NUM_BEATS)-1:0]         beat_idx_t;

  // ----------------------------------------------------------
  // Encodings
  typedef enum logic [1:0] {
    MSG_MOM = 2'b00,
    MSG_SOM = 2'b01,
    MSG_EOM = 2'b10
  } msg_cntl_e;

  typedef enum logic {
    PKT_NA   = 1'b0,
    PKT_DATA = 1'b1
  } pkt_type_e;

  typedef enum logic [1:0] {
    ST_WAIT, ST_MOM, ST_EOM, ST_COMPLETE
  } xfer_state_e;

endpackage

// File: design/up_beat_if.sv
// Upstream beat link between transfer controller and beat FIFO
//   One beat per cycle with write high
//   almost_full back to the controller

interface up_beat_if
  import sui_pkg::*;
();

  logic      write;        // Beat valid, stored every cycle it is high
  msg_cntl_e cntl;
  pkt_type_e pkt_type;
  bus_data_t data;
  tag_t      oob;
  logic      almost_full;  // Occupancy at or above threshold

  // Controller side
  modport ctrl (
    output write, cntl, pkt_type, data, oob,
    input  almost_full
  );

  // FIFO side
  modport fifo (
    input  write, cntl, pkt_type, data, oob,
    output almost_full
  );

endinterface

// File: design/sui_input_capture.sv
// Input capture for the SIMD side
//   Per-lane registers loaded by lanes_valid
//   Tag latch held until the next valid lane set
//   Registered send level

`include "sui_params.svh"

module sui_input_capture
  import sui_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  lane_array_t               lanes,
  input  logic [`SUI_NUM_LANES-1:0] lanes_valid,
  input  tag_t                      tag,
  input  logic                      send,
  output lane_array_t               lanes_q,
  output tag_t                      tag_q,
  output logic                      send_q
);

  // ----------------------------------------------------------
  // Lane registers

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `SUI_NUM_LANES; i++)
    begin
      if (lanes_valid[i])
        lanes_q[i*`SUI_LANE_WIDTH +: `SUI_LANE_WIDTH] <= lanes[i*`SUI_LANE_WIDTH +: `SUI_LANE_WIDTH];
    end
  end

  // Tag follows any valid lane set
  always_ff @(posedge clk)
  begin
    if (|lanes_valid)
      tag_q <= tag;
  end

  // ----------------------------------------------------------
  // Send level

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      send_q <= 1'b0;
    else
      send_q <= send;  // Level, held by SIMD until regs_complete
  end

endmodule

// File: design/sui_transfer_ctrl.sv
// Transfer controller from lane registers to the beat FIFO
//   Transfer FSM and beat counter
//   Lane-pair select, message marker and packet type
//   regs_ready and regs_complete status to the SIMD side

`include "sui_params.svh"

module sui_transfer_ctrl
  import sui_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  lane_array_t lanes_q,
  input  tag_t        tag_q,
  input  logic        send_q,
  up_beat_if.ctrl     beat,
  output logic        regs_ready,
  output logic        regs_complete
);

  typedef logic [$clog2(`SUI_NUM_LANES)-1:0] lane_idx_t;

  localparam beat_idx_t LAST_BEAT = beat_idx_t'(`SUI_NUM_BEATS - 1);
  localparam beat_idx_t PRE_LAST  = beat_idx_t'(`SUI_NUM_BEATS - 2);

  xfer_state_e state;
  xfer_state_e state_next;
  beat_idx_t   beat_idx;   // Beat being offered to the FIFO
  logic        wr_beat;
  lane_idx_t   lo_idx;
  lane_idx_t   hi_idx;
  lane_t       lane_lo;
  lane_t       lane_hi;

  // ----------------------------------------------------------
  // Write qualification
  // No write in any state while the FIFO is almost full

  always_comb
  begin
    wr_beat = 1'b0;
    case (state)
      ST_WAIT: wr_beat = send_q && !beat.almost_full;  // Beat 0
      ST_MOM:  wr_beat = !beat.almost_full;
      ST_EOM:  wr_beat = !beat.almost_full;            // Last beat
      default: wr_beat = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Next state

  always_comb
  begin
    state_next = state;
    case (state)
      ST_WAIT:
        if (wr_beat)
          state_next = ST_MOM;
      ST_MOM:
        if (wr_beat && beat_idx == PRE_LAST)
          state_next = ST_EOM;
      ST_EOM:
        if (wr_beat)
          state_next = ST_COMPLETE;
      ST_COMPLETE:
        if (!send_q)
          state_next = ST_WAIT;   // SIMD has seen regs_complete
      default:
        state_next = ST_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state         <= ST_WAIT;
      beat_idx      <= '0;
      regs_ready    <= 1'b0;
      regs_complete <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (wr_beat)
        beat_idx <= beat_idx + 1'b1;  // Wraps to 0 after the last beat
      regs_ready    <= (state == ST_WAIT);
      regs_complete <= (state == ST_EOM && wr_beat) || (state == ST_COMPLETE);
    end
  end

  // ----------------------------------------------------------
  // Beat contents

  // Lane pair for the current beat
  assign lo_idx  = lane_idx_t'(beat_idx) * lane_idx_t'(`SUI_LANES_PER_BEAT);
  assign hi_idx  = lo_idx + 1'b1;
  assign lane_lo = lanes_q[lo_idx*`SUI_LANE_WIDTH +: `SUI_LANE_WIDTH];
  assign lane_hi = lanes_q[hi_idx*`SUI_LANE_WIDTH +: `SUI_LANE_WIDTH];

  always_comb
  begin
    if (beat_idx == '0)
      beat.cntl = MSG_SOM;
    else if (beat_idx == LAST_BEAT)
      beat.cntl = MSG_EOM;
    else
      beat.cntl = MSG_MOM;
  end

  assign beat.pkt_type = (beat_idx == '0) ? PKT_DATA : PKT_NA;  // Header type on first beat only
  assign beat.data     = {lane_hi, lane_lo};
  assign beat.oob      = tag_q;
  assign beat.write    = wr_beat;

endmodule

// File: design/sui_upstream_fifo.sv
// Beat FIFO and drain to the upstream stack bus
//   Circular buffer with read/write pointers and occupancy
//   almost_full status from registered occupancy
//   Registered bus ready and one pop per ready cycle

`include "sui_params.svh"

module sui_upstream_fifo
  import sui_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      up_ready,
  up_beat_if.fifo   beat,
  output logic      up_valid,
  output msg_cntl_e up_cntl,
  output pkt_type_e up_type,
  output bus_data_t up_data,
  output tag_t      up_oob
);

  localparam int PTR_W   = $clog2(`SUI_FIFO_DEPTH);
  localparam int COUNT_W = $clog2(`SUI_FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0]   ptr_t;
  typedef logic [COUNT_W-1:0] count_t;

  localparam ptr_t   LAST_PTR  = ptr_t'(`SUI_FIFO_DEPTH - 1);
  localparam count_t THRESHOLD = count_t'(`SUI_FIFO_THRESHOLD);

  // Storage
  msg_cntl_e cntl_mem [`SUI_FIFO_DEPTH];
  pkt_type_e type_mem [`SUI_FIFO_DEPTH];
  bus_data_t data_mem [`SUI_FIFO_DEPTH];
  tag_t      oob_mem  [`SUI_FIFO_DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   ready_q;
  logic   pop;

  // ----------------------------------------------------------
  // Write side

  always_ff @(posedge clk)
  begin
    if (beat.write)
    begin
      cntl_mem[wr_ptr] <= beat.cntl;
      type_mem[wr_ptr] <= beat.pkt_type;
      data_mem[wr_ptr] <= beat.data;
      oob_mem[wr_ptr]  <= beat.oob;
    end
  end

  // ----------------------------------------------------------
  // Pointers, occupancy and registered ready

  assign pop = ready_q && (count != '0);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      ready_q <= 1'b0;
    end
    else
    begin
      ready_q <= up_ready;
      if (beat.write)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({beat.write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign beat.almost_full = (count >= THRESHOLD);  // Headroom left for beats in flight

  // Head entry onto the bus
  assign up_valid = pop;
  assign up_cntl  = cntl_mem[rd_ptr];
  assign up_type  = type_mem[rd_ptr];
  assign up_data  = data_mem[rd_ptr];
  assign up_oob   = oob_mem[rd_ptr];

endmodule

// File: design/simd_upstream_intf.sv
// SIMD upstream interface top level
//   Input capture of the SIMD lane registers
//   Transfer controller into the beat FIFO
//   Beat FIFO draining to the upstream stack bus

`include "sui_params.svh"

module simd_upstream_intf
  import sui_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,

  // SIMD side
  input  lane_array_t               lanes,
  input  logic [`SUI_NUM_LANES-1:0] lanes_valid,
  input  tag_t                      tag,
  input  logic                      send,
  output logic                      regs_ready,
  output logic                      regs_complete,

  // Stack upstream bus
  input  logic                      up_ready,
  output logic                      up_valid,
  output msg_cntl_e                 up_cntl,
  output pkt_type_e                 up_type,
  output bus_data_t                 up_data,
  output tag_t                      up_oob
);

  lane_array_t lanes_q;
  tag_t        tag_q;
  logic        send_q;

  up_beat_if beat_if ();  // Controller to FIFO

  // ----------------------------------------------------------
  // Blocks

  sui_input_capture u_capture (
    .clk         (clk),
    .arst_n      (arst_n),
    .lanes       (lanes),
    .lanes_valid (lanes_valid),
    .tag         (tag),
    .send        (send),
    .lanes_q     (lanes_q),
    .tag_q       (tag_q),
    .send_q      (send_q)
  );

  sui_transfer_ctrl u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .lanes_q       (lanes_q),
    .tag_q         (tag_q),
    .send_q        (send_q),
    .beat          (beat_if.ctrl),
    .regs_ready    (regs_ready),
    .regs_complete (regs_complete)
  );

  sui_upstream_fifo u_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .up_ready (up_ready),
    .beat     (beat_if.fifo),
    .up_valid (up_valid),
    .up_cntl  (up_cntl),
    .up_type  (up_type),
    .up_data  (up_data),
    .up_oob   (up_oob)
  );

endmodule

// File: tests/tb_sui.sv
// Testbench for the SIMD upstream interface
//   Packets read from tests/sui_trace.txt
//   Random bus ready with one long low-ready phase
//   Expected-beat queue checked against the upstream bus
//   Status checks on regs_ready and regs_complete

`include "sui_params.svh"

module tb_sui
  import sui_pkg::*;
();

  localparam int NUM_PKTS       = 7;
  localparam int WORDS_PER_PKT  = `SUI_NUM_LANES + 2;  // Tag, lanes, gap
  localparam int STALL_PKT      = 3;                   // Low-ready phase starts here
  localparam int STALL_CYCLES   = 40;
  localparam int TIMEOUT_CYCLES = 300 * NUM_PKTS + 100;

  typedef struct packed {
    msg_cntl_e cntl;
    pkt_type_e ptype;
    bus_data_t data;
    tag_t      oob;
  } beat_t;

  logic                      clk;
  logic                      arst_n;
  lane_array_t               lanes;
  logic [`SUI_NUM_LANES-1:0] lanes_valid;
  tag_t                      tag;
  logic                      send;
  logic                      regs_ready;
  logic                      regs_complete;
  logic                      up_ready;
  logic                      up_valid;
  msg_cntl_e                 up_cntl;
  pkt_type_e                 up_type;
  bus_data_t                 up_data;
  tag_t                      up_oob;

  logic [31:0] trace_mem [NUM_PKTS*WORDS_PER_PKT];
  beat_t       expect_q [$];
  integer      seed = 32'h46b0_cbc9;
  int          stall_left = 0;
  int          cycle_count = 0;
  int          complete_rises = 0;
  int          beats_seen = 0;
  logic        complete_prev = 1'b0;
  logic        ready_seen;        // up_ready as the DUT sampled it

  simd_upstream_intf UUT (
    .clk           (clk),
    .arst_n        (arst_n),
    .lanes         (lanes),
    .lanes_valid   (lanes_valid),
    .tag           (tag),
    .send          (send),
    .regs_ready    (regs_ready),
    .regs_complete (regs_complete),
    .up_ready      (up_ready),
    .up_valid      (up_valid),
    .up_cntl       (up_cntl),
    .up_type       (up_type),
    .up_data       (up_data),
    .up_oob        (up_oob)
  );

  initial
    clk = 1'b0;
  always #10 clk = ~clk;

  // ----------------------------------------------------------
  // Error reporting

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string what);
    stop_with_failure($sformatf("mismatch at %0t: %s", $time, what));
  endtask

  // ----------------------------------------------------------
  // Stimulus helpers

  // Advance to the next falling edge and drive bus ready
  task automatic next_cycle();
    logic [31:0] rnd;
    @(negedge clk);
    rnd = $random(seed);
    if (stall_left > 0)
    begin
      up_ready   = 1'b0;
      stall_left = stall_left - 1;
    end
    else
      up_ready = rnd[0];
  endtask

  // Beat k carries lanes 2k and 2k+1
  task automatic push_expected(input int base);
    beat_t b;
    for (int k = 0; k < `SUI_NUM_BEATS; k++)
    begin
      b.data = {trace_mem[base + 2 + 2*k], trace_mem[base + 1 + 2*k]};
      b.oob  = tag_t'(trace_mem[base]);
      if (k == 0)
        b.cntl = MSG_SOM;
      else if (k == `SUI_NUM_BEATS - 1)
        b.cntl = MSG_EOM;
      else
        b.cntl = MSG_MOM;
      b.ptype = (k == 0) ? PKT_DATA : PKT_NA;  // Header type on first beat only
      expect_q.push_back(b);
    end
  endtask

  task automatic send_packet(input int p);
    int base;
    int gap;
    int waited;
    base = p * WORDS_PER_PKT;
    gap  = int'(trace_mem[base + WORDS_PER_PKT - 1]);
    next_cycle();
    for (int i = 0; i < `SUI_NUM_LANES; i++)
      lanes[i*`SUI_LANE_WIDTH +: `SUI_LANE_WIDTH] = trace_mem[base + 1 + i];
    tag         = tag_t'(trace_mem[base]);
    lanes_valid = '1;
    send        = 1'b1;
    push_expected(base);
    do
      next_cycle();
    while (!regs_complete);
    if (p == STALL_PKT + 1)
      assert (stall_left == 0)
        else stop_with_failure(
          "second packet of the low-ready phase finished before ready returned");
    send        = 1'b0;
    lanes_valid = '0;
    waited = 0;
    while (regs_complete && waited < 4)
    begin
      next_cycle();
      waited++;
    end
    assert (!regs_complete)
      else stop_with_failure("regs_complete stayed high after send was dropped");
    repeat (gap) next_cycle();
  endtask

  // ----------------------------------------------------------
  // Main sequence

  initial
  begin
    arst_n      = 1'b0;
    lanes       = '0;
    lanes_valid = '0;
    tag         = '0;
    send        = 1'b0;
    up_ready    = 1'b0;
    $readmemh("tests/sui_trace.txt", trace_mem);
    assert (!$isunknown(trace_mem[0]))
      else stop_with_failure("trace file tests/sui_trace.txt could not be read");

    next_cycle();
    assert (!regs_ready && !regs_complete && !up_valid)
      else stop_with_failure("status outputs not low during reset");
    next_cycle();
    arst_n = 1'b1;
    next_cycle();
    assert (regs_ready && !regs_complete)
      else stop_with_failure("regs_ready did not rise on the first clock after reset");

    for (int p = 0; p < NUM_PKTS; p++)
    begin
      if (p == STALL_PKT)
        stall_left = STALL_CYCLES;
      send_packet(p);
    end

    while (expect_q.size() != 0)
      next_cycle();
    repeat (10) next_cycle();  // Catch any extra beat
    @(posedge clk);

    if (expect_q.size() == 0 && complete_rises == NUM_PKTS)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
      stop_with_failure($sformatf("run ended with %0d beats left and %0d of %0d completions",
                                  expect_q.size(), complete_rises, NUM_PKTS));
  end

  // ----------------------------------------------------------
  // Bus and status monitor

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ready_seen <= 1'b0;
    else
      ready_seen <= up_ready;
  end

  always @(negedge clk)
  begin : bus_monitor
    beat_t head;
    if (arst_n)
    begin
      if (up_valid)
      begin
        assert (ready_seen)
          else stop_with_failure("up_valid high in a cycle after up_ready was sampled low");
        assert (expect_q.size() > 0)
          else stop_with_failure("beat on the upstream bus with no beat expected");
        head = expect_q.pop_front();
        assert (up_data === head.data)
          else report_mismatch($sformatf("beat %0d up_data %h, expected %h",
                                         beats_seen, up_data, head.data));
        assert (up_oob === head.oob)
          else report_mismatch($sformatf("beat %0d up_oob %h, expected %h",
                                         beats_seen, up_oob, head.oob));
        assert (up_cntl === head.cntl)
          else report_mismatch($sformatf("beat %0d up_cntl %s, expected %s",
                                         beats_seen, up_cntl.name(), head.cntl.name()));
        assert (up_type === head.ptype)
          else report_mismatch($sformatf("beat %0d up_type %s, expected %s",
                                         beats_seen, up_type.name(), head.ptype.name()));
        beats_seen++;
      end
      assert (!(regs_ready && regs_complete))
        else stop_with_failure("regs_ready and regs_complete were high together");
      if (regs_complete && !complete_prev)
        complete_rises++;  // One per packet
      complete_prev = regs_complete;
    end
  end

  // Cycle limit
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure($sformatf("timeout, the run did not finish within %0d cycles",
                                  TIMEOUT_CYCLES));
  end

endmodule

// File: tests/sui_trace.txt
// Columns: tag, lane0 .. lane7, idle gap in cycles after the packet (all hex)
// Packet 3 starts the low-ready phase, its short gap lets packet 4 queue behind it
a1 10000001 10000002 10000003 10000004 10000005 10000006 10000007 10000008 03
b2 2badf00d 20000012 20000023 20000034 20000045 20000056 20000067 20000078 00
c3 deadbeef cafebabe 01234567 89abcdef fedcba98 76543210 0f0f0f0f f0f0f0f0 05
d4 40004001 40014002 40024003 40034004 40044005 40054006 40064007 40074008 01
e5 55aa55aa aa55aa55 5a5a5a5a a5a5a5a5 00ff00ff ff00ff00 12481248 84218421 02
f6 60606060 61616161 62626262 63636363 64646464 65656565 66666666 67676767 00
07 ffffffff 00000000 80000000 00000001 7fffffff fffffffe 13579bdf 2468ace0 04

// File: verilog.f
+incdir+design
design/sui_pkg.sv
design/up_beat_if.sv
design/sui_input_capture.sv
design/sui_transfer_ctrl.sv
design/sui_upstream_fifo.sv
design/simd_upstream_intf.sv
tests/tb_sui.sv

// File: Bender.yml
package:
  name: simd_upstream_intf

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/sui_pkg.sv
      - design/up_beat_if.sv
      - design/sui_input_capture.sv
      - design/sui_transfer_ctrl.sv
      - design/sui_upstream_fifo.sv
      - design/simd_upstream_intf.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_sui.sv
